// File: design/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

  // what the stage has to do with the data cache
  typedef enum logic [1:0] {
    kind_none  = 2'd0,
    kind_load  = 2'd1,
    kind_store = 2'd2
  } mem_kind_e;

  // access size, also the log2 of the byte count
  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_half  = 2'd1,
    size_word  = 2'd2,
    size_dword = 2'd3
  } mem_size_e;

  // compact opcode, lbu = {kind_load, size_byte, 1}
  typedef struct packed {
    mem_kind_e  kind;
    mem_size_e  size;
    logic       is_unsigned; // zero extend on load, ignored for stores
  } mem_op_t;

  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_translate = 2'd1, // waiting for xlate_ack
    st_read      = 2'd2, // waiting for the read cache_ack
    st_write     = 2'd3  // waiting for the write cache_ack
  } fsm_state_e;

endpackage

`default_nettype wire

// File: design/mem_data_pkg.sv
`default_nettype none

package mem_data_pkg;

  localparam int xlen = 64;
  localparam int regno_width = 5;
  localparam int lane_sel_width = 3; // byte offset inside one 64-bit word

  // one memory word seen as bytes, halves, words or a single dword.
  // index 0 of every view is the least significant lane
  typedef union packed {
    logic [7:0][7:0]  bytes;
    logic [3:0][15:0] halves;
    logic [1:0][31:0] words;
    logic [63:0]      dword;
  } mem_word_u;

endpackage

`default_nettype wire

// File: design/load_align.sv
`timescale 1ns/10ps
`default_nettype none

module load_align (
  input  mem_data_pkg::mem_word_u                 rdata,
  input  mem_op_pkg::mem_size_e                   size,
  input  logic                                    is_unsigned,
  input  logic [mem_data_pkg::lane_sel_width-1:0] offset,
  output logic [mem_data_pkg::xlen-1:0]           load_value
);

  localparam int xlen = mem_data_pkg::xlen;

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;
  logic [31:0] word_lane;
  logic        sext;

  // low offset bits below the lane size are zero for aligned accesses
  assign byte_lane = rdata.bytes[offset];
  assign half_lane = rdata.halves[offset[2:1]];
  assign word_lane = rdata.words[offset[2]];
  assign sext      = !is_unsigned;

  always_comb begin
    case (size)
      mem_op_pkg::size_byte: begin
        load_value = {{(xlen-8){sext & byte_lane[7]}}, byte_lane};
      end
      mem_op_pkg::size_half: begin
        load_value = {{(xlen-16){sext & half_lane[15]}}, half_lane};
      end
      mem_op_pkg::size_word: begin
        load_value = {{(xlen-32){sext & word_lane[31]}}, word_lane}; // lw vs lwu
      end
      default: begin
        load_value = rdata.dword;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/store_merge.sv
`timescale 1ns/10ps
`default_nettype none

module store_merge (
  input  mem_data_pkg::mem_word_u                 rdata,
  input  mem_op_pkg::mem_size_e                   size,
  input  logic [mem_data_pkg::lane_sel_width-1:0] offset,
  input  logic [mem_data_pkg::xlen-1:0]           store_value,
  output mem_data_pkg::mem_word_u                 merged_word
);

  // start from the old word and overwrite just the addressed lane,
  // the union view picks the lane width
  always_comb begin
    merged_word = rdata;
    case (size)
      mem_op_pkg::size_byte: begin
        merged_word.bytes[offset] = store_value[7:0];
      end
      mem_op_pkg::size_half: begin
        merged_word.halves[offset[2:1]] = store_value[15:0];
      end
      mem_op_pkg::size_word: begin
        merged_word.words[offset[2]] = store_value[31:0];
      end
      default: begin
        merged_word.dword = store_value; // sd bypasses this path anyway
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/mem_wb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_regs (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  flush,
  input  logic                                  capture,
  input  logic [mem_data_pkg::xlen-1:0]         load_value,
  input  logic                                  is_load,
  input  logic [mem_data_pkg::xlen-1:0]         alu_result,
  input  logic [mem_data_pkg::xlen-1:0]         rs2_value,
  input  logic [mem_data_pkg::xlen-1:0]         pc_target,
  input  logic [mem_data_pkg::regno_width-1:0]  rd_regno,
  input  logic                                  update_rd,
  input  logic                                  branch_taken,
  input  logic                                  load_flag,
  output logic                                  done,
  output logic [mem_data_pkg::xlen-1:0]         mdata,
  output logic [mem_data_pkg::xlen-1:0]         alu_result_out,
  output logic [mem_data_pkg::xlen-1:0]         rs2_value_out,
  output logic [mem_data_pkg::xlen-1:0]         pc_target_out,
  output logic [mem_data_pkg::regno_width-1:0]  rd_regno_out,
  output logic                                  update_rd_out,
  output logic                                  branch_taken_out,
  output logic                                  load_flag_out
);

  // upstream keeps the forwarded fields stable from start until done,
  // so they are sampled here on the final capture
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      done             <= 1'b0;
      mdata            <= '0;
      alu_result_out   <= '0;
      rs2_value_out    <= '0;
      pc_target_out    <= '0;
      rd_regno_out     <= '0;
      update_rd_out    <= 1'b0;
      branch_taken_out <= 1'b0;
      load_flag_out    <= 1'b0;
    end else begin
      done <= capture; // one pulse per finished op
      if (capture) begin
        mdata            <= is_load ? load_value : '0;
        alu_result_out   <= alu_result;
        rs2_value_out    <= rs2_value;
        pc_target_out    <= pc_target;
        rd_regno_out     <= rd_regno;
        update_rd_out    <= update_rd;
        branch_taken_out <= branch_taken;
        load_flag_out    <= load_flag;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/mem_access_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access_fsm #(
  parameter int paddr_width = 40
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    start,
  input  logic                                    flush,
  input  mem_op_pkg::mem_op_t                     op,
  input  logic [mem_data_pkg::xlen-1:0]           alu_result,
  input  logic [mem_data_pkg::xlen-1:0]           rs2_value,
  input  logic                                    xlate_ack,
  input  logic [paddr_width-1:0]                  xlate_paddr,
  input  logic                                    cache_ack,
  input  mem_data_pkg::mem_word_u                 merged_word,
  output logic                                    xlate_req,
  output logic [mem_data_pkg::xlen-1:0]           xlate_vaddr,
  output logic                                    cache_rd,
  output logic                                    cache_wr,
  output logic [paddr_width-1:0]                  cache_addr,
  output logic [mem_data_pkg::xlen-1:0]           cache_wdata,
  output logic                                    capture,
  output mem_op_pkg::mem_op_t                     held_op,
  output logic [mem_data_pkg::lane_sel_width-1:0] held_offset,
  output logic [mem_data_pkg::xlen-1:0]           held_rs2
);

  mem_op_pkg::fsm_state_e state;

  logic is_sd;
  assign is_sd = (held_op.kind == mem_op_pkg::kind_store) &&
                 (held_op.size == mem_op_pkg::size_dword);

  // non-memory ops finish in the start cycle, memory ops on their last ack
  assign capture = (state == mem_op_pkg::st_idle && start &&
                    op.kind == mem_op_pkg::kind_none) ||
                   (state == mem_op_pkg::st_read && cache_ack &&
                    held_op.kind == mem_op_pkg::kind_load) ||
                   (state == mem_op_pkg::st_write && cache_ack);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= mem_op_pkg::st_idle;
      held_op     <= '0;
      xlate_req   <= 1'b0;
      xlate_vaddr <= '0;
      cache_rd    <= 1'b0;
      cache_wr    <= 1'b0;
      cache_addr  <= '0;
      cache_wdata <= '0;
    end else if (flush) begin
      state        <= mem_op_pkg::st_idle; // any ack still in flight is dropped in idle
      held_op.kind <= mem_op_pkg::kind_none;
      xlate_req    <= 1'b0;
      cache_rd     <= 1'b0;
      cache_wr     <= 1'b0;
    end else begin
      xlate_req <= 1'b0; // all requests are single-cycle strobes
      cache_rd  <= 1'b0;
      cache_wr  <= 1'b0;
      case (state)
        mem_op_pkg::st_idle: begin
          if (start && op.kind != mem_op_pkg::kind_none) begin
            held_op     <= op;
            xlate_vaddr <= {alu_result[mem_data_pkg::xlen-1:3], 3'b000};
            xlate_req   <= 1'b1;
            state       <= mem_op_pkg::st_translate;
          end
        end
        mem_op_pkg::st_translate: begin
          if (xlate_ack) begin
            cache_addr <= xlate_paddr;
            if (is_sd) begin
              cache_wdata <= held_rs2; // full word, no read needed
              cache_wr    <= 1'b1;
              state       <= mem_op_pkg::st_write;
            end else begin
              cache_rd <= 1'b1;
              state    <= mem_op_pkg::st_read;
            end
          end
        end
        mem_op_pkg::st_read: begin
          if (cache_ack) begin
            if (held_op.kind == mem_op_pkg::kind_store) begin
              cache_wdata <= merged_word.dword;
              cache_wr    <= 1'b1;
              state       <= mem_op_pkg::st_write;
            end else begin
              held_op.kind <= mem_op_pkg::kind_none;
              state        <= mem_op_pkg::st_idle;
            end
          end
        end
        mem_op_pkg::st_write: begin
          if (cache_ack) begin
            held_op.kind <= mem_op_pkg::kind_none;
            state        <= mem_op_pkg::st_idle;
          end
        end
        default: state <= mem_op_pkg::st_idle;
      endcase
    end
  end

  // lane select and store data only matter while an access is open
  always_ff @(posedge clk) begin
    if (state == mem_op_pkg::st_idle && start) begin
      held_offset <= alu_result[mem_data_pkg::lane_sel_width-1:0];
      held_rs2    <= rs2_value;
    end
  end

  a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
    start && !flush |-> state == mem_op_pkg::st_idle)
    else $error("start issued while an access is in progress");

  // in 3 bits the mask wraps to 3'b111 for a dword
  a_aligned: assert property (@(posedge clk) disable iff (reset)
    start && op.kind != mem_op_pkg::kind_none |->
      (alu_result[2:0] & ((3'd1 << op.size) - 3'd1)) == 3'd0)
    else $error("misaligned access, offset %0d", alu_result[2:0]);

  a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(cache_rd && cache_wr))
    else $error("cache read and write in the same cycle");

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage #(
  parameter int paddr_width = 40
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  start,
  input  logic                                  flush,
  input  mem_op_pkg::mem_op_t                   op,
  input  logic [mem_data_pkg::xlen-1:0]         alu_result,
  input  logic [mem_data_pkg::xlen-1:0]         rs2_value,
  input  logic [mem_data_pkg::xlen-1:0]         pc_target,
  input  logic [mem_data_pkg::regno_width-1:0]  rd_regno,
  input  logic                                  update_rd,
  input  logic                                  branch_taken,
  input  logic                                  load_flag,
  // translation port
  output logic                                  xlate_req,
  output logic [mem_data_pkg::xlen-1:0]         xlate_vaddr,
  input  logic                                  xlate_ack,
  input  logic [paddr_width-1:0]                xlate_paddr,
  // data cache port
  output logic                                  cache_rd,
  output logic                                  cache_wr,
  output logic [paddr_width-1:0]                cache_addr,
  output logic [mem_data_pkg::xlen-1:0]         cache_wdata,
  input  logic                                  cache_ack,
  input  logic [mem_data_pkg::xlen-1:0]         cache_rdata,
  // to writeback
  output logic                                  done,
  output logic [mem_data_pkg::xlen-1:0]         mdata,
  output logic [mem_data_pkg::xlen-1:0]         alu_result_out,
  output logic [mem_data_pkg::xlen-1:0]         rs2_value_out,
  output logic [mem_data_pkg::xlen-1:0]         pc_target_out,
  output logic [mem_data_pkg::regno_width-1:0]  rd_regno_out,
  output logic                                  update_rd_out,
  output logic                                  branch_taken_out,
  output logic                                  load_flag_out
);

  logic                                    capture;
  mem_op_pkg::mem_op_t                     held_op;
  logic [mem_data_pkg::lane_sel_width-1:0] held_offset;
  logic [mem_data_pkg::xlen-1:0]           held_rs2;
  logic [mem_data_pkg::xlen-1:0]           load_value;
  mem_data_pkg::mem_word_u                 merged_word;

  mem_access_fsm #(
    .paddr_width(paddr_width)
  ) u_fsm (
    .clk(clk),
    .reset(reset),
    .start(start),
    .flush(flush),
    .op(op),
    .alu_result(alu_result),
    .rs2_value(rs2_value),
    .xlate_ack(xlate_ack),
    .xlate_paddr(xlate_paddr),
    .cache_ack(cache_ack),
    .merged_word(merged_word),
    .xlate_req(xlate_req),
    .xlate_vaddr(xlate_vaddr),
    .cache_rd(cache_rd),
    .cache_wr(cache_wr),
    .cache_addr(cache_addr),
    .cache_wdata(cache_wdata),
    .capture(capture),
    .held_op(held_op),
    .held_offset(held_offset),
    .held_rs2(held_rs2)
  );

  // both data paths look at the read word in the cycle of its ack
  load_align u_load_align (
    .rdata(cache_rdata),
    .size(held_op.size),
    .is_unsigned(held_op.is_unsigned),
    .offset(held_offset),
    .load_value(load_value)
  );

  store_merge u_store_merge (
    .rdata(cache_rdata),
    .size(held_op.size),
    .offset(held_offset),
    .store_value(held_rs2),
    .merged_word(merged_word)
  );

  mem_wb_regs u_wb_regs (
    .clk(clk),
    .reset(reset),
    .flush(flush),
    .capture(capture),
    .load_value(load_value),
    .is_load(held_op.kind == mem_op_pkg::kind_load),
    .alu_result(alu_result),
    .rs2_value(rs2_value),
    .pc_target(pc_target),
    .rd_regno(rd_regno),
    .update_rd(update_rd),
    .branch_taken(branch_taken),
    .load_flag(load_flag),
    .done(done),
    .mdata(mdata),
    .alu_result_out(alu_result_out),
    .rs2_value_out(rs2_value_out),
    .pc_target_out(pc_target_out),
    .rd_regno_out(rd_regno_out),
    .update_rd_out(update_rd_out),
    .branch_taken_out(branch_taken_out),
    .load_flag_out(load_flag_out)
  );

endmodule

`default_nettype wire

// File: verif/mem_responder.sv
`timescale 1ns/10ps
`default_nettype none

module mem_responder #(
  parameter int          paddr_width = 40,
  parameter logic [31:0] seed        = 32'h1
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   xlate_req,
  input  logic [63:0]            xlate_vaddr,
  output logic                   xlate_ack,
  output logic [paddr_width-1:0] xlate_paddr,
  input  logic                   cache_rd,
  input  logic                   cache_wr,
  input  logic [paddr_width-1:0] cache_addr,
  input  logic [63:0]            cache_wdata,
  output logic                   cache_ack,
  output logic [63:0]            cache_rdata
);

  logic [63:0] mem [16]; // indexed by paddr bits 6:3
  logic [31:0] rng;
  logic [2:0]  x_wait;
  logic [2:0]  c_wait;
  logic [63:0] x_vaddr;
  logic [63:0] c_wdata;
  logic [3:0]  c_index;
  logic        c_write;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  always @(posedge clk) begin
    logic [31:0] s;
    logic [31:0] hi;
    if (reset) begin
      s = seed;
      for (int i = 0; i < 16; i++) begin
        hi = xorshift(s);
        s = xorshift(hi);
        mem[i] <= {hi, s};
      end
      rng         <= s;
      xlate_ack   <= 1'b0;
      cache_ack   <= 1'b0;
      xlate_paddr <= '0;
      cache_rdata <= '0;
      x_wait      <= 3'd0;
      c_wait      <= 3'd0;
    end else begin
      xlate_ack <= 1'b0;
      cache_ack <= 1'b0;
      if (xlate_req) begin
        rng     <= xorshift(rng);
        x_wait  <= {1'b0, rng[1:0]} + 3'd1; // 1 to 4 cycles
        x_vaddr <= xlate_vaddr;
      end else if (x_wait == 3'd1) begin
        xlate_ack   <= 1'b1;
        xlate_paddr <= paddr_width'(x_vaddr ^ 64'h10_0000);
        x_wait      <= 3'd0;
      end else if (x_wait != 3'd0) begin
        x_wait <= x_wait - 3'd1;
      end
      if (cache_rd || cache_wr) begin
        rng     <= xorshift(rng);
        c_wait  <= {1'b0, rng[2:1]} + 3'd1;
        c_index <= cache_addr[6:3];
        c_write <= cache_wr;
        c_wdata <= cache_wdata;
      end else if (c_wait == 3'd1) begin
        cache_ack   <= 1'b1;
        cache_rdata <= mem[c_index];
        if (c_write) mem[c_index] <= c_wdata; // acks after a flush still land here
        c_wait <= 3'd0;
      end else if (c_wait != 3'd0) begin
        c_wait <= c_wait - 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

  localparam int          paddr_width = 40;
  localparam int          xlen = mem_data_pkg::xlen;
  localparam logic [31:0] seed = 32'hb62c_99be;
  localparam int          max_cycles = 200 * 14; // ops times worst case cycles per op

  logic clk, reset, start, flush;
  mem_op_pkg::mem_op_t op;
  logic [xlen-1:0] alu_result, rs2_value, pc_target;
  logic [4:0] rd_regno;
  logic update_rd, branch_taken, load_flag;
  logic xlate_req, xlate_ack, cache_rd, cache_wr, cache_ack, done;
  logic [xlen-1:0] xlate_vaddr, cache_wdata, cache_rdata, mdata;
  logic [paddr_width-1:0] xlate_paddr, cache_addr;
  logic [xlen-1:0] alu_result_out, rs2_value_out, pc_target_out;
  logic [4:0] rd_regno_out;
  logic update_rd_out, branch_taken_out, load_flag_out;

  logic [63:0] model [16];
  logic [31:0] rng;
  logic [63:0] wr_data;
  int errors, checks, tests, cycles, err0, chk0;
  int n_xreq, n_rd, n_wr, rd_at, wr_at, latency;

  mem_stage #(.paddr_width(paddr_width)) dut (.*);

  mem_responder #(.paddr_width(paddr_width), .seed(seed)) resp (
    .clk(clk), .reset(reset),
    .xlate_req(xlate_req), .xlate_vaddr(xlate_vaddr),
    .xlate_ack(xlate_ack), .xlate_paddr(xlate_paddr),
    .cache_rd(cache_rd), .cache_wr(cache_wr), .cache_addr(cache_addr),
    .cache_wdata(cache_wdata), .cache_ack(cache_ack), .cache_rdata(cache_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, an operation never finished", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic next_rand64(output logic [63:0] r);
    logic [31:0] hi;
    hi = xorshift(rng);
    rng = xorshift(hi);
    r = {hi, rng};
  endtask

  // extended lane as the load instructions define it
  function automatic logic [63:0] lane_of(input logic [63:0] w, input int size,
                                          input bit uns, input int off);
    logic [63:0] v;
    logic [63:0] mask;
    int bits;
    bits = 8 << size;
    v = w >> (off * 8);
    if (bits == 64) return v;
    mask = (64'd1 << bits) - 64'd1;
    v = v & mask;
    if (!uns && v[bits-1]) v = v | ~mask;
    return v;
  endfunction

  function automatic logic [63:0] merged(input logic [63:0] w, input logic [63:0] val,
                                         input int size, input int off);
    logic [63:0] mask;
    mask = (64'd1 << (8 << size)) - 64'd1;
    return (w & ~(mask << (off * 8))) | ((val & mask) << (off * 8));
  endfunction

  function automatic mem_op_pkg::mem_op_t make_op(input mem_op_pkg::mem_kind_e kind,
                                                  input int size, input bit uns);
    mem_op_pkg::mem_op_t o;
    o.kind = kind;
    o.size = mem_op_pkg::mem_size_e'(size[1:0]);
    o.is_unsigned = uns;
    return o;
  endfunction

  task automatic make_addr(input int idx, input int off, output logic [63:0] a);
    logic [63:0] r;
    next_rand64(r);
    a = {r[63:7], 4'(idx), 3'(off)};
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("t=%0t %s", $time, what);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    chk0 = checks;
    err0 = errors;
  endtask

  // one op from start to done, logging strobes on the way
  task automatic issue_op(input mem_op_pkg::mem_op_t o, input logic [63:0] alu,
                          input logic [63:0] rs2);
    logic [63:0] r;
    next_rand64(r);
    op = o;
    alu_result = alu;
    rs2_value = rs2;
    pc_target = r;
    rd_regno = r[4:0];
    update_rd = r[5];
    branch_taken = r[6];
    load_flag = r[7];
    start = 1'b1;
    n_xreq = 0;
    n_rd = 0;
    n_wr = 0;
    rd_at = 0;
    wr_at = 0;
    latency = 1;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (!done) begin
      if (xlate_req) n_xreq++;
      if (cache_rd) begin
        n_rd++;
        rd_at = latency;
      end
      if (cache_wr) begin
        n_wr++;
        wr_at = latency;
        wr_data = cache_wdata;
      end
      @(posedge clk);
      #1;
      latency++;
    end
    check_true(!(xlate_req || cache_rd || cache_wr), "request strobe active together with done");
    check_value("alu_result_out", alu_result_out, alu);
    check_value("rs2_value_out", rs2_value_out, rs2);
    check_value("pc_target_out", pc_target_out, r);
    check_value("rd_regno_out", 64'(rd_regno_out), 64'(r[4:0]));
    check_value("update_rd_out/branch_taken_out/load_flag_out",
                64'({update_rd_out, branch_taken_out, load_flag_out}), 64'({r[5], r[6], r[7]}));
  endtask

  task automatic load_and_check(input int sz, input bit uns, input int idx, input int off);
    logic [63:0] a;
    make_addr(idx, off, a);
    issue_op(make_op(mem_op_pkg::kind_load, sz, uns), a, 64'd0);
    check_value("mdata", mdata, lane_of(model[idx], sz, uns, off));
    check_value("xlate_vaddr", xlate_vaddr, a & ~64'd7);
    check_value("cache_addr", 64'(cache_addr),
                64'(paddr_width'((a & ~64'd7) ^ 64'h10_0000)));
    check_value("translate count", 64'(n_xreq), 64'd1);
    check_value("cache_rd count", 64'(n_rd), 64'd1);
    check_value("cache_wr count", 64'(n_wr), 64'd0);
  endtask

  task automatic store_and_check(input int sz, input int idx, input int off);
    logic [63:0] a;
    logic [63:0] v;
    logic [63:0] w;
    make_addr(idx, off, a);
    next_rand64(v);
    w = (sz == 3) ? v : merged(model[idx], v, sz, off);
    issue_op(make_op(mem_op_pkg::kind_store, sz, 1'b0), a, v);
    check_value("cache_wdata", wr_data, w);
    check_value("mdata", mdata, 64'd0);
    check_value("cache_rd count", 64'(n_rd), (sz == 3) ? 64'd0 : 64'd1);
    check_true(n_wr == 1 && (sz == 3 || rd_at < wr_at), "cache_wr missing or not after cache_rd");
    model[idx] = w;
    load_and_check(3, 1'b0, idx, 0);
  endtask

  task automatic flush_during(input bit in_read);
    logic [63:0] a;
    int idx;
    idx = int'(rng[3:0]);
    make_addr(idx, 0, a);
    op = make_op(mem_op_pkg::kind_load, 3, 1'b0);
    alu_result = a;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (!(in_read ? cache_rd : xlate_req)) begin
      @(posedge clk);
      #1;
    end
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    check_value("mdata", mdata, 64'd0);
    check_value("alu_result_out", alu_result_out, 64'd0);
    check_value("pc_target_out", pc_target_out, 64'd0);
    repeat (8) begin // long enough for any late ack to drain
      check_true(!(done || xlate_req || cache_rd || cache_wr), "strobe or done after a flush");
      @(posedge clk);
      #1;
    end
    load_and_check(3, 1'b0, idx, 0);
  endtask

  initial begin
    logic [31:0] hi;
    logic [63:0] a;
    logic [63:0] v;
    reset = 1'b1;
    start = 1'b0;
    flush = 1'b0;
    op = '0;
    alu_result = '0;
    rs2_value = '0;
    pc_target = '0;
    rd_regno = '0;
    update_rd = 1'b0;
    branch_taken = 1'b0;
    load_flag = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    cycles = 0;
    err0 = 0;
    chk0 = 0;
    // same preload sequence as the responder
    rng = seed;
    for (int i = 0; i < 16; i++) begin
      hi = xorshift(rng);
      rng = xorshift(hi);
      model[i] = {hi, rng};
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    check_true(!(done || xlate_req || cache_rd || cache_wr), "strobe active after reset");
    check_value("mdata", mdata, 64'd0);
    check_value("alu_result_out", alu_result_out, 64'd0);
    check_value("rs2_value_out", rs2_value_out, 64'd0);
    check_value("pc_target_out", pc_target_out, 64'd0);
    check_value("rd_regno_out/flags", 64'({rd_regno_out, update_rd_out, branch_taken_out,
                load_flag_out}), 64'd0);
    check_value("cache_addr", 64'(cache_addr), 64'd0);
    check_value("cache_wdata", cache_wdata, 64'd0);
    check_value("xlate_vaddr", xlate_vaddr, 64'd0);
    end_test("reset");

    for (int sz = 0; sz < 4; sz++)
      for (int uns = 0; uns < 2; uns++)
        for (int off = 0; off < 8; off += (1 << sz))
          if (!(sz == 3 && uns == 1)) load_and_check(sz, uns[0], int'(rng[3:0]), off);
    end_test("loads");

    for (int i = 0; i < 4; i++) store_and_check(3, int'(rng[3:0]), 0);
    end_test("sd then ld");

    for (int sz = 0; sz < 3; sz++)
      for (int off = 0; off < 8; off += (1 << sz))
        store_and_check(sz, int'(rng[3:0]), off);
    end_test("sub-dword stores");

    for (int i = 0; i < 4; i++) begin
      next_rand64(a);
      next_rand64(v);
      issue_op(make_op(mem_op_pkg::kind_none, 0, 1'b0), a, v);
      check_value("done latency", 64'(latency), 64'd1);
      check_value("request strobe count", 64'(n_xreq + n_rd + n_wr), 64'd0);
      check_value("mdata", mdata, 64'd0);
    end
    end_test("non-memory");

    flush_during(1'b0);
    flush_during(1'b1);
    end_test("flush");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
design/mem_op_pkg.sv
design/mem_data_pkg.sv
design/load_align.sv
design/store_merge.sv
design/mem_wb_regs.sv
design/mem_access_fsm.sv
design/mem_stage.sv
verif/mem_responder.sv
verif/tb_mem_stage.sv

// File: run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_mem_stage -f all.f \
  && ./obj_dir/Vtb_mem_stage > sim.log 2>&1 \
  || echo "build or simulation stopped with an error" >> sim.log
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
